// File: hw/tile_config.svh
// --------------------
// Tile configuration
// Group size, queue depths and payload width
// --------------------

`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// Dispatch group and commit window
`define TILE_DISP_SIZE      2
`define TILE_CMT_ENTRY_SIZE 8

// Issue queue credits per category
`define TILE_ALU_ENTRY_SIZE 4
`define TILE_LSU_ENTRY_SIZE 4
`define TILE_BRU_ENTRY_SIZE 2
`define TILE_CSU_ENTRY_SIZE 1

`define TILE_DATA_W         32
`define TILE_CAT_NUM        4

`endif

// File: hw/tile_pkg.sv
// --------------------
// Tile types
// Dispatch slot, commit id and done report formats
// --------------------

`include "tile_config.svh"

package tile_pkg;

  // Category indices for the per-category vectors and done ports
  localparam int CAT_IDX_ALU = 0;
  localparam int CAT_IDX_LSU = 1;
  localparam int CAT_IDX_BRU = 2;
  localparam int CAT_IDX_CSU = 3;

  localparam int CMT_ID_W   = $clog2(`TILE_CMT_ENTRY_SIZE) + 1;
  localparam int DISP_CNT_W = $clog2(`TILE_DISP_SIZE + 1);

  typedef enum logic [2:0] {
    INST_CAT_ALU = 3'd0,
    INST_CAT_LD  = 3'd1,
    INST_CAT_ST  = 3'd2,
    INST_CAT_BR  = 3'd3,
    INST_CAT_CSU = 3'd4
  } inst_cat_t;

  typedef struct packed {
    logic        valid;
    logic        illegal;
    inst_cat_t   cat;
    logic [15:0] tag;
  } disp_slot_t;

  // Entry index plus wrap bit
  typedef logic [CMT_ID_W-1:0] cmt_id_t;
  typedef logic [`TILE_DISP_SIZE-1:0] grp_id_t;
  typedef logic [DISP_CNT_W-1:0] disp_cnt_t;

  typedef enum logic [7:0] {
    EXC_ILLEGAL = 8'd2,
    EXC_UNIT    = 8'd5
  } except_cause_t;

  typedef struct packed {
    except_cause_t cause;
    logic [23:0]   tval;
  } except_info_t;

  // Result word, or cause and trap value when except is set
  typedef union packed {
    logic [`TILE_DATA_W-1:0] result;
    except_info_t            exc;
  } done_payload_u;

  typedef struct packed {
    logic          valid;
    cmt_id_t       cmt_id;
    grp_id_t       grp_id;
    logic          except;
    done_payload_u payload;
  } done_rpt_t;

endpackage

// File: hw/tile_ifs.sv
// --------------------
// Dispatch and credit/return interfaces
// --------------------

`include "tile_config.svh"

interface disp_if;
  logic                 valid;
  logic                 ready;
  tile_pkg::disp_slot_t slots[`TILE_DISP_SIZE];
  // Per-category slot valids and slot counts
  tile_pkg::grp_id_t    cat_valid[`TILE_CAT_NUM];
  tile_pkg::disp_cnt_t  cat_demand[`TILE_CAT_NUM];
  tile_pkg::cmt_id_t    cmt_id;

  modport master (output valid, slots, input ready, cmt_id);
  modport steer  (input valid, output cat_valid, cat_demand);
  modport alloc  (input valid, cat_demand, output ready);
  modport rob    (input valid, ready, slots, cat_valid, output cmt_id);
endinterface

// One instance per credit pool
interface cre_ret_if;
  logic                alloc;
  tile_pkg::disp_cnt_t alloc_cnt;
  logic                ret;
  tile_pkg::disp_cnt_t ret_cnt;
  logic                ok;

  modport counter  (input alloc, alloc_cnt, ret, ret_cnt, output ok);
  modport returner (output ret, ret_cnt);
endinterface

// File: hw/disp_steer.sv
// --------------------
// Dispatch steering
// Slot valids and demand counts per category
// --------------------

`include "tile_config.svh"

module disp_steer (
  input tile_pkg::disp_slot_t i_slots[`TILE_DISP_SIZE],
  disp_if.steer               o_disp
);

  logic [`TILE_DISP_SIZE-1:0] w_live;
  tile_pkg::grp_id_t          w_cat_valid[`TILE_CAT_NUM];
  tile_pkg::disp_cnt_t        w_demand[`TILE_CAT_NUM];

  // Illegal slots never reach a unit
  always_comb begin
    for (int d = 0; d < `TILE_DISP_SIZE; d++) begin
      w_live[d] = o_disp.valid & i_slots[d].valid & ~i_slots[d].illegal;
    end
  end

  always_comb begin
    for (int d = 0; d < `TILE_DISP_SIZE; d++) begin
      w_cat_valid[tile_pkg::CAT_IDX_ALU][d] = w_live[d] &
        (i_slots[d].cat == tile_pkg::INST_CAT_ALU);
      // Loads and stores share the LSU
      w_cat_valid[tile_pkg::CAT_IDX_LSU][d] = w_live[d] &
        ((i_slots[d].cat == tile_pkg::INST_CAT_LD) |
         (i_slots[d].cat == tile_pkg::INST_CAT_ST));
      w_cat_valid[tile_pkg::CAT_IDX_BRU][d] = w_live[d] &
        (i_slots[d].cat == tile_pkg::INST_CAT_BR);
      w_cat_valid[tile_pkg::CAT_IDX_CSU][d] = w_live[d] &
        (i_slots[d].cat == tile_pkg::INST_CAT_CSU);
    end
  end

  // Population count per category
  always_comb begin
    for (int c = 0; c < `TILE_CAT_NUM; c++) begin
      w_demand[c] = '0;
      for (int d = 0; d < `TILE_DISP_SIZE; d++) begin
        w_demand[c] = w_demand[c] + tile_pkg::disp_cnt_t'(w_cat_valid[c][d]);
      end
    end
  end

  for (genvar c = 0; c < `TILE_CAT_NUM; c++) begin : g_cat_out
    assign o_disp.cat_valid[c]  = w_cat_valid[c];
    assign o_disp.cat_demand[c] = w_demand[c];
  end

endmodule

// File: hw/credit_counter.sv
// --------------------
// Credit pool
// Free count taken on allocation, refilled on return
// --------------------

module credit_counter #(
  parameter int MAX_CREDIT = 4
) (
  input logic        i_clk,
  input logic        i_reset,
  cre_ret_if.counter cre
);

  localparam int CNT_W = $clog2(MAX_CREDIT + 1);

  logic [CNT_W-1:0] r_free;
  int               w_next;

  // Compare at full width so a large request never wraps
  assign cre.ok = int'(cre.alloc_cnt) <= int'(r_free);

  always_comb begin
    w_next = int'(r_free);
    if (cre.alloc) begin
      w_next = w_next - int'(cre.alloc_cnt);
    end
    if (cre.ret) begin
      w_next = w_next + int'(cre.ret_cnt);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_free <= CNT_W'(MAX_CREDIT);
    end else begin
      r_free <= CNT_W'(w_next);
    end
  end

endmodule

// File: hw/resource_alloc.sv
// --------------------
// Resource allocation
// ROB and issue queue credit check for a dispatch group
// --------------------

`include "tile_config.svh"

module resource_alloc (
  input logic   i_clk,
  input logic   i_reset,
  disp_if.alloc disp,
  cre_ret_if    rob_cre,
  cre_ret_if    alu_cre,
  cre_ret_if    lsu_cre,
  cre_ret_if    bru_cre,
  cre_ret_if    csu_cre
);

  logic w_ready;
  logic w_accept;

  // Group goes only when every pool can take it
  assign w_ready    = rob_cre.ok & alu_cre.ok & lsu_cre.ok & bru_cre.ok & csu_cre.ok;
  assign disp.ready = w_ready;
  assign w_accept   = disp.valid & w_ready;

  // One ROB entry per group
  assign rob_cre.alloc     = w_accept;
  assign rob_cre.alloc_cnt = tile_pkg::disp_cnt_t'(1);

  assign alu_cre.alloc     = w_accept;
  assign alu_cre.alloc_cnt = disp.cat_demand[tile_pkg::CAT_IDX_ALU];
  assign lsu_cre.alloc     = w_accept;
  assign lsu_cre.alloc_cnt = disp.cat_demand[tile_pkg::CAT_IDX_LSU];
  assign bru_cre.alloc     = w_accept;
  assign bru_cre.alloc_cnt = disp.cat_demand[tile_pkg::CAT_IDX_BRU];
  assign csu_cre.alloc     = w_accept;
  assign csu_cre.alloc_cnt = disp.cat_demand[tile_pkg::CAT_IDX_CSU];

  // --------------------
  // Credit pools
  // --------------------
  credit_counter #(.MAX_CREDIT(`TILE_CMT_ENTRY_SIZE)) u_rob_credit (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .cre     (rob_cre)
  );

  credit_counter #(.MAX_CREDIT(`TILE_ALU_ENTRY_SIZE)) u_alu_credit (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .cre     (alu_cre)
  );

  credit_counter #(.MAX_CREDIT(`TILE_LSU_ENTRY_SIZE)) u_lsu_credit (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .cre     (lsu_cre)
  );

  credit_counter #(.MAX_CREDIT(`TILE_BRU_ENTRY_SIZE)) u_bru_credit (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .cre     (bru_cre)
  );

  credit_counter #(.MAX_CREDIT(`TILE_CSU_ENTRY_SIZE)) u_csu_credit (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .cre     (csu_cre)
  );

endmodule

// File: hw/rob.sv
// --------------------
// Reorder buffer
// One entry per group, done tracking and in-order commit
// --------------------

`include "tile_config.svh"

module rob (
  input  logic                    i_clk,
  input  logic                    i_reset,
  disp_if.rob                     disp,
  input  tile_pkg::done_rpt_t     i_done_rpt[`TILE_CAT_NUM],
  cre_ret_if.returner             rob_ret,
  cre_ret_if.returner             alu_ret,
  cre_ret_if.returner             lsu_ret,
  cre_ret_if.returner             bru_ret,
  cre_ret_if.returner             csu_ret,
  output logic                    o_commit_valid,
  output tile_pkg::cmt_id_t       o_commit_cmt_id,
  output tile_pkg::grp_id_t       o_commit_grp_id,
  output tile_pkg::grp_id_t       o_commit_except,
  output tile_pkg::done_payload_u o_commit_payload[`TILE_DISP_SIZE]
);

  localparam int IDX_W = $clog2(`TILE_CMT_ENTRY_SIZE);

  tile_pkg::cmt_id_t       r_head;
  tile_pkg::cmt_id_t       r_tail;
  logic [IDX_W-1:0]        w_head_idx;
  logic [IDX_W-1:0]        w_tail_idx;
  logic                    w_accept;

  // Entry storage
  tile_pkg::grp_id_t       r_slot_valid[`TILE_CMT_ENTRY_SIZE];
  tile_pkg::grp_id_t       r_done[`TILE_CMT_ENTRY_SIZE];
  tile_pkg::grp_id_t       r_except[`TILE_CMT_ENTRY_SIZE];
  tile_pkg::done_payload_u r_payload[`TILE_CMT_ENTRY_SIZE][`TILE_DISP_SIZE];

  tile_pkg::grp_id_t       w_no_unit;
  tile_pkg::done_payload_u w_ill_payload[`TILE_DISP_SIZE];

  assign w_accept    = disp.valid & disp.ready;
  assign w_head_idx  = r_head[IDX_W-1:0];
  assign w_tail_idx  = r_tail[IDX_W-1:0];
  assign disp.cmt_id = r_tail;

  // Slots steered to no unit are done at dispatch
  always_comb begin
    for (int s = 0; s < `TILE_DISP_SIZE; s++) begin
      w_no_unit[s] = 1'b1;
      for (int c = 0; c < `TILE_CAT_NUM; c++) begin
        if (disp.cat_valid[c][s]) begin
          w_no_unit[s] = 1'b0;
        end
      end
      w_ill_payload[s].exc.cause = tile_pkg::EXC_ILLEGAL;
      w_ill_payload[s].exc.tval  = 24'(disp.slots[s].tag);
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      for (int s = 0; s < `TILE_DISP_SIZE; s++) begin
        r_slot_valid[w_tail_idx][s] <= disp.slots[s].valid;
        r_done[w_tail_idx][s]       <= w_no_unit[s];
        r_except[w_tail_idx][s]     <= disp.slots[s].valid & disp.slots[s].illegal;
        r_payload[w_tail_idx][s]    <= w_ill_payload[s];
      end
    end
    // Done reports from the units
    for (int p = 0; p < `TILE_CAT_NUM; p++) begin
      if (i_done_rpt[p].valid) begin
        for (int s = 0; s < `TILE_DISP_SIZE; s++) begin
          if (i_done_rpt[p].grp_id[s]) begin
            r_done[i_done_rpt[p].cmt_id[IDX_W-1:0]][s]    <= 1'b1;
            r_except[i_done_rpt[p].cmt_id[IDX_W-1:0]][s]  <= i_done_rpt[p].except;
            r_payload[i_done_rpt[p].cmt_id[IDX_W-1:0]][s] <= i_done_rpt[p].payload;
          end
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_head <= '0;
      r_tail <= '0;
    end else begin
      if (w_accept) begin
        r_tail <= r_tail + 1'b1;
      end
      if (o_commit_valid) begin
        r_head <= r_head + 1'b1;
      end
    end
  end

  // --------------------
  // Commit and returns
  // --------------------
  assign o_commit_valid  = (r_head != r_tail) & (&r_done[w_head_idx]);
  assign o_commit_cmt_id = r_head;
  assign o_commit_grp_id = r_slot_valid[w_head_idx];
  assign o_commit_except = r_except[w_head_idx];

  for (genvar s = 0; s < `TILE_DISP_SIZE; s++) begin : g_cmt_payload
    assign o_commit_payload[s] = r_payload[w_head_idx][s];
  end

  assign rob_ret.ret     = o_commit_valid;
  assign rob_ret.ret_cnt = tile_pkg::disp_cnt_t'(1);
  assign alu_ret.ret     = i_done_rpt[tile_pkg::CAT_IDX_ALU].valid;
  assign alu_ret.ret_cnt = tile_pkg::disp_cnt_t'(1);
  assign lsu_ret.ret     = i_done_rpt[tile_pkg::CAT_IDX_LSU].valid;
  assign lsu_ret.ret_cnt = tile_pkg::disp_cnt_t'(1);
  assign bru_ret.ret     = i_done_rpt[tile_pkg::CAT_IDX_BRU].valid;
  assign bru_ret.ret_cnt = tile_pkg::disp_cnt_t'(1);
  assign csu_ret.ret     = i_done_rpt[tile_pkg::CAT_IDX_CSU].valid;
  assign csu_ret.ret_cnt = tile_pkg::disp_cnt_t'(1);

endmodule

// File: hw/tile_top.sv
// --------------------
// Tile top
// Dispatch, credit allocation and ROB commit path
// --------------------

`include "tile_config.svh"

module tile_top (
  input  logic                    i_clk,
  input  logic                    i_reset,

  // Dispatch group
  input  logic                    i_disp_valid,
  output logic                    o_disp_ready,
  input  tile_pkg::disp_slot_t    i_disp_slots[`TILE_DISP_SIZE],
  output tile_pkg::cmt_id_t       o_disp_cmt_id,

  // One done port per category
  input  tile_pkg::done_rpt_t     i_done_rpt[`TILE_CAT_NUM],

  // Commit
  output logic                    o_commit_valid,
  output tile_pkg::cmt_id_t       o_commit_cmt_id,
  output tile_pkg::grp_id_t       o_commit_grp_id,
  output tile_pkg::grp_id_t       o_commit_except,
  output tile_pkg::done_payload_u o_commit_payload[`TILE_DISP_SIZE]
);

  disp_if    w_disp ();
  cre_ret_if w_rob_cre ();
  cre_ret_if w_alu_cre ();
  cre_ret_if w_lsu_cre ();
  cre_ret_if w_bru_cre ();
  cre_ret_if w_csu_cre ();

  assign w_disp.valid  = i_disp_valid;
  assign w_disp.slots  = i_disp_slots;
  assign o_disp_ready  = w_disp.ready;
  assign o_disp_cmt_id = w_disp.cmt_id;

  disp_steer u_disp_steer (
    .i_slots (w_disp.slots),
    .o_disp  (w_disp)
  );

  resource_alloc u_resource_alloc (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .disp    (w_disp),
    .rob_cre (w_rob_cre),
    .alu_cre (w_alu_cre),
    .lsu_cre (w_lsu_cre),
    .bru_cre (w_bru_cre),
    .csu_cre (w_csu_cre)
  );

  rob u_rob (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .disp             (w_disp),
    .i_done_rpt       (i_done_rpt),
    .rob_ret          (w_rob_cre),
    .alu_ret          (w_alu_cre),
    .lsu_ret          (w_lsu_cre),
    .bru_ret          (w_bru_cre),
    .csu_ret          (w_csu_cre),
    .o_commit_valid   (o_commit_valid),
    .o_commit_cmt_id  (o_commit_cmt_id),
    .o_commit_grp_id  (o_commit_grp_id),
    .o_commit_except  (o_commit_except),
    .o_commit_payload (o_commit_payload)
  );

endmodule

// File: bench/tb_checker.sv
// --------------------
// Tile checker
// Credit model for ready, golden compare of commits
// --------------------

`include "tile_config.svh"

module tb_checker (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_disp_valid,
  input  tile_pkg::disp_slot_t    i_disp_slots[`TILE_DISP_SIZE],
  input  logic                    i_disp_ready,
  input  tile_pkg::cmt_id_t       i_disp_cmt_id,
  input  tile_pkg::done_rpt_t     i_done_rpt[`TILE_CAT_NUM],
  input  logic                    i_commit_valid,
  input  tile_pkg::cmt_id_t       i_commit_cmt_id,
  input  tile_pkg::grp_id_t       i_commit_grp_id,
  input  tile_pkg::grp_id_t       i_commit_except,
  input  tile_pkg::done_payload_u i_commit_payload[`TILE_DISP_SIZE],
  output int                      o_err_cnt,
  output int                      o_commit_cnt,
  output int                      o_exp_cnt
);

  int          e_grp_no[64];
  logic [31:0] e_grp_id[64];
  logic [31:0] e_except[64];
  logic [31:0] e_pay[64][`TILE_DISP_SIZE];

  int rob_free;
  int unit_free[`TILE_CAT_NUM];
  int acc_cnt;

  function automatic int unit_of_cat(tile_pkg::inst_cat_t c);
    case (c)
      tile_pkg::INST_CAT_LD, tile_pkg::INST_CAT_ST: return 1;
      tile_pkg::INST_CAT_BR:                        return 2;
      tile_pkg::INST_CAT_CSU:                       return 3;
      default:                                      return 0;
    endcase
  endfunction

  task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      o_err_cnt++;
    end
  endtask

  // Only E records matter here
  initial begin
    int                 fd;
    int                 code;
    logic [8*8-1:0]     tok;
    logic [8*256-1:0]   line;
    o_err_cnt    = 0;
    o_commit_cnt = 0;
    o_exp_cnt    = 0;
    fd = $fopen("bench/tile_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file for the expected commits");
      o_err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        if (tok == "E") begin
          code = $fscanf(fd, "%d %h %h %h %h", e_grp_no[o_exp_cnt], e_grp_id[o_exp_cnt],
                         e_except[o_exp_cnt], e_pay[o_exp_cnt][0], e_pay[o_exp_cnt][1]);
          o_exp_cnt++;
        end else begin
          code = $fgets(line, fd);
        end
      end
      $fclose(fd);
    end
  end

  always @(negedge i_clk) begin
    int   demand[`TILE_CAT_NUM];
    logic exp_ready;
    int   n;
    if (i_reset !== 1'b0) begin
      rob_free = `TILE_CMT_ENTRY_SIZE;
      unit_free[0] = `TILE_ALU_ENTRY_SIZE;
      unit_free[1] = `TILE_LSU_ENTRY_SIZE;
      unit_free[2] = `TILE_BRU_ENTRY_SIZE;
      unit_free[3] = `TILE_CSU_ENTRY_SIZE;
      acc_cnt = 0;
    end else begin
      for (int c = 0; c < `TILE_CAT_NUM; c++) demand[c] = 0;
      for (int s = 0; s < `TILE_DISP_SIZE; s++) begin
        if (i_disp_valid && i_disp_slots[s].valid && !i_disp_slots[s].illegal) begin
          demand[unit_of_cat(i_disp_slots[s].cat)]++;
        end
      end
      exp_ready = (rob_free >= 1);
      for (int c = 0; c < `TILE_CAT_NUM; c++) begin
        if (unit_free[c] < demand[c]) exp_ready = 1'b0;
      end
      compare("ready", 32'(exp_ready), 32'(i_disp_ready));

      // Accepted group takes its credits
      if (i_disp_valid && exp_ready) begin
        compare("disp_cmt_id", 32'(acc_cnt % 16), 32'(i_disp_cmt_id));
        rob_free--;
        for (int c = 0; c < `TILE_CAT_NUM; c++) unit_free[c] -= demand[c];
        acc_cnt++;
      end
      for (int p = 0; p < `TILE_CAT_NUM; p++) begin
        if (i_done_rpt[p].valid) unit_free[p]++;
      end

      if (i_commit_valid) begin
        rob_free++;
        if (o_commit_cnt >= o_exp_cnt) begin
          $display("A commit arrived after the last expected group");
          o_err_cnt++;
        end else begin
          n = o_commit_cnt;
          compare("commit_cmt_id", 32'(e_grp_no[n] % 16), 32'(i_commit_cmt_id));
          compare("commit_grp_id", e_grp_id[n], 32'(i_commit_grp_id));
          compare("commit_except", e_except[n], 32'(i_commit_except));
          for (int s = 0; s < `TILE_DISP_SIZE; s++) begin
            if (e_grp_id[n][s]) compare("commit_payload", e_pay[n][s], i_commit_payload[s]);
          end
        end
        o_commit_cnt++;
      end
    end
  end

endmodule

// File: bench/tb_top.sv
// --------------------
// Tile testbench
// Golden-file dispatch, done reports and watchdog
// --------------------

`include "tile_config.svh"

module tb_top;

  logic                    clk;
  logic                    reset;
  logic                    disp_valid;
  logic                    disp_ready;
  tile_pkg::disp_slot_t    disp_slots[`TILE_DISP_SIZE];
  tile_pkg::cmt_id_t       disp_cmt_id;
  tile_pkg::done_rpt_t     done_rpt[`TILE_CAT_NUM];
  logic                    commit_valid;
  tile_pkg::cmt_id_t       commit_cmt_id;
  tile_pkg::grp_id_t       commit_grp_id;
  tile_pkg::grp_id_t       commit_except;
  tile_pkg::done_payload_u commit_payload[`TILE_DISP_SIZE];

  int err_cnt;
  int commit_cnt;
  int exp_cnt;

  // Stimulus from the golden file
  tile_pkg::disp_slot_t d_slot[64][`TILE_DISP_SIZE];
  int                   n_d;
  int                   r_grp[64];
  int                   r_slot[64];
  logic [31:0]          r_exc[64];
  logic [31:0]          r_pay[64];
  int                   n_r;
  int                   n_rec;
  logic                 loaded;
  logic                 accepted[64];
  tile_pkg::cmt_id_t    cmt_of[64];

  tile_top UUT (
    .i_clk (clk), .i_reset (reset),
    .i_disp_valid (disp_valid), .o_disp_ready (disp_ready),
    .i_disp_slots (disp_slots), .o_disp_cmt_id (disp_cmt_id),
    .i_done_rpt (done_rpt),
    .o_commit_valid (commit_valid), .o_commit_cmt_id (commit_cmt_id),
    .o_commit_grp_id (commit_grp_id), .o_commit_except (commit_except),
    .o_commit_payload (commit_payload)
  );

  tb_checker u_checker (
    .i_clk (clk), .i_reset (reset),
    .i_disp_valid (disp_valid), .i_disp_slots (disp_slots),
    .i_disp_ready (disp_ready), .i_disp_cmt_id (disp_cmt_id),
    .i_done_rpt (done_rpt),
    .i_commit_valid (commit_valid), .i_commit_cmt_id (commit_cmt_id),
    .i_commit_grp_id (commit_grp_id), .i_commit_except (commit_except),
    .i_commit_payload (commit_payload),
    .o_err_cnt (err_cnt), .o_commit_cnt (commit_cnt), .o_exp_cnt (exp_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int port_of_cat(tile_pkg::inst_cat_t c);
    case (c)
      tile_pkg::INST_CAT_LD, tile_pkg::INST_CAT_ST: return 1;
      tile_pkg::INST_CAT_BR:                        return 2;
      tile_pkg::INST_CAT_CSU:                       return 3;
      default:                                      return 0;
    endcase
  endfunction

  task automatic load_golden();
    int               fd;
    int               code;
    int               g;
    int               v[2];
    int               il[2];
    int               ct[2];
    logic [15:0]      tg[2];
    logic [8*8-1:0]   tok;
    logic [8*256-1:0] line;
    fd = $fopen("bench/tile_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden stimulus file");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok == "D") begin
        code = $fscanf(fd, "%d %d %d %d %h %d %d %d %h", g, v[0], il[0], ct[0], tg[0],
                       v[1], il[1], ct[1], tg[1]);
        for (int s = 0; s < `TILE_DISP_SIZE; s++) begin
          d_slot[g][s].valid   = v[s][0];
          d_slot[g][s].illegal = il[s][0];
          d_slot[g][s].cat     = tile_pkg::inst_cat_t'(ct[s][2:0]);
          d_slot[g][s].tag     = tg[s];
        end
        n_d++;
        n_rec++;
      end else if (tok == "R") begin
        code = $fscanf(fd, "%d %d %h %h", r_grp[n_r], r_slot[n_r], r_exc[n_r], r_pay[n_r]);
        n_r++;
        n_rec++;
      end else if (tok == "E") begin
        code = $fgets(line, fd);
        n_rec++;
      end else begin
        code = $fgets(line, fd);
      end
    end
    $fclose(fd);
  endtask

  task automatic dispatch_groups();
    for (int g = 0; g < n_d; g++) begin
      @(posedge clk);
      disp_valid <= 1'b1;
      for (int s = 0; s < `TILE_DISP_SIZE; s++) disp_slots[s] <= d_slot[g][s];
      @(negedge clk);
      while (!disp_ready) @(negedge clk);
      cmt_of[g]   = disp_cmt_id;
      accepted[g] = 1'b1;
    end
    @(posedge clk);
    disp_valid <= 1'b0;
    for (int s = 0; s < `TILE_DISP_SIZE; s++) disp_slots[s] <= '0;
  endtask

  // Each report waits for its group, then a random delay
  task automatic send_reports();
    tile_pkg::done_rpt_t rpt;
    int                  port;
    for (int i = 0; i < n_r; i++) begin
      wait (accepted[r_grp[i]]);
      repeat ($urandom % 4) @(posedge clk);
      port = port_of_cat(d_slot[r_grp[i]][r_slot[i]].cat);
      rpt = '0;
      rpt.valid          = 1'b1;
      rpt.cmt_id         = cmt_of[r_grp[i]];
      rpt.grp_id         = tile_pkg::grp_id_t'(1 << r_slot[i]);
      rpt.except         = r_exc[i][0];
      rpt.payload.result = r_pay[i];
      @(posedge clk);
      done_rpt[port] <= rpt;
      @(posedge clk);
      done_rpt[port] <= '0;
    end
  endtask

  initial begin
    void'($urandom(18027));
    n_d = 0;
    n_r = 0;
    n_rec = 0;
    loaded = 1'b0;
    for (int g = 0; g < 64; g++) accepted[g] = 1'b0;
    reset = 1'b1;
    disp_valid = 1'b0;
    for (int s = 0; s < `TILE_DISP_SIZE; s++) disp_slots[s] = '0;
    for (int p = 0; p < `TILE_CAT_NUM; p++) done_rpt[p] = '0;
    load_golden();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    fork
      dispatch_groups();
      send_reports();
    join
    wait (commit_cnt >= exp_cnt);
    repeat (4) @(posedge clk);
    $display("Errors: %0d, commits seen %0d of %0d expected", err_cnt, commit_cnt, exp_cnt);
    if (err_cnt == 0 && commit_cnt == exp_cnt && n_d > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized by the record count
  initial begin
    wait (loaded);
    repeat (n_rec * 20 + 10) @(posedge clk);
    $display("Timeout: only %0d of %0d groups committed", commit_cnt, exp_cnt);
    $display("Errors: %0d, commits seen %0d of %0d expected", err_cnt, commit_cnt, exp_cnt);
    $display("Test failed");
    $finish;
  end

endmodule

// File: bench/tile_golden.txt
# D group v0 ill0 cat0 tag0 v1 ill1 cat1 tag1   (cat 0 ALU 1 LD 2 ST 3 BR 4 CSU)
# R group slot except payload   |   E group grp_id except payload0 payload1
D 0 1 0 0 0010 1 0 3 0011
D 1 1 0 3 0020 1 0 1 0021
D 2 1 0 3 0030 0 0 0 0000
D 3 1 1 0 0040 1 0 2 0041
D 4 1 0 0 0050 0 0 0 0000
D 5 1 0 1 0060 1 0 0 0061
D 6 1 0 4 0070 0 0 0 0000
D 7 1 0 0 0080 0 0 0 0000
D 8 1 0 3 0090 0 0 0 0000
D 9 1 0 2 00A0 0 0 0 0000
D 10 1 0 0 00B0 1 0 0 00B1
D 11 1 0 1 00C0 1 0 3 00C1
R 1 0 0 11110020
R 0 1 0 11110011
R 0 0 0 11110010
R 1 1 0 11110021
R 2 0 0 11110030
R 4 0 0 11110050
R 5 1 0 11110061
R 5 0 0 11110060
R 6 0 0 11110070
R 7 0 0 11110080
R 8 0 1 05000090
R 9 0 0 111100A0
R 10 0 0 111100B0
R 10 1 0 111100B1
R 3 1 0 11110041
R 11 0 0 111100C0
R 11 1 1 050000C1
E 0 3 0 11110010 11110011
E 1 3 0 11110020 11110021
E 2 1 0 11110030 00000000
E 3 3 1 02000040 11110041
E 4 1 0 11110050 00000000
E 5 3 0 11110060 11110061
E 6 1 0 11110070 00000000
E 7 1 0 11110080 00000000
E 8 1 1 05000090 00000000
E 9 1 0 111100A0 00000000
E 10 3 0 111100B0 111100B1
E 11 3 2 111100C0 050000C1

// File: list.f
+incdir+hw
hw/tile_pkg.sv
hw/tile_ifs.sv
hw/disp_steer.sv
hw/credit_counter.sv
hw/resource_alloc.sv
hw/rob.sv
hw/tile_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and logs"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module tb_top \
		--Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
